// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module uart_tb \
	-o Vuart_tb

# The result is taken from the simulator output
output=$(./obj_dir/Vuart_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== testbench/uart_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

	import uart_pkg::*;

	typedef enum logic [1:0] {
		INJ_NONE       = 2'd0,
		INJ_BAD_PARITY = 2'd1,
		INJ_BAD_STOP   = 2'd2
	} inject_t;

	// Stimulus followed by the receive flags expected for it
	typedef struct packed {
		logic [7:0] data;
		logic [7:0] cts_delay;
		inject_t    mode;
		logic       extra_start;
		logic       exp_parity_err;
		logic       exp_frame_err;
	} entry_t;

	localparam int NUM_ENTRIES     = 8;
	localparam int RESET_CYCLES    = 4;
	localparam int MAX_CTS_DELAY   = 12;
	localparam int MARGIN_CYCLES   = 40;
	localparam int FRAME_CYCLES    = FRAME_BITS * CLKS_PER_BIT;
	localparam int RX_TIMEOUT      = 4 * CLKS_PER_BIT;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES
		+ NUM_ENTRIES * (FRAME_CYCLES + MAX_CTS_DELAY + MARGIN_CYCLES);

	logic       Clk;
	logic       Rst;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       cts;
	logic       tx;
	logic       tx_busy;
	logic       rx;
	logic [7:0] rx_data;
	logic       rx_valid;
	logic       rx_parity_err;
	logic       rx_frame_err;

	logic        loop_en;
	logic        rx_drive;
	logic [31:0] lfsr_state = 32'hfeee;
	entry_t      table_q [NUM_ENTRIES];

	// Normal entries loop tx back to rx and the others let the testbench drive the line
	assign rx = loop_en ? tx : rx_drive;

	uart_top dut_i (
		.Clk           (Clk),
		.Rst           (Rst),
		.tx_start      (tx_start),
		.tx_data       (tx_data),
		.cts           (cts),
		.tx            (tx),
		.tx_busy       (tx_busy),
		.rx            (rx),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.rx_parity_err (rx_parity_err),
		.rx_frame_err  (rx_frame_err)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	initial begin
		table_q[0] = '{8'hA5, 8'd0, INJ_NONE, 1'b0, 1'b0, 1'b0};
		table_q[1] = '{8'h3C, 8'd5, INJ_NONE, 1'b1, 1'b0, 1'b0};
		table_q[2] = '{8'h00, 8'd0, INJ_NONE, 1'b1, 1'b0, 1'b0};
		table_q[3] = '{8'hFF, 8'd12, INJ_NONE, 1'b0, 1'b0, 1'b0};
		table_q[4] = '{8'h96, 8'd0, INJ_BAD_PARITY, 1'b0, 1'b1, 1'b0};
		table_q[5] = '{8'h5A, 8'd0, INJ_BAD_STOP, 1'b0, 1'b0, 1'b1};
		table_q[6] = '{8'h81, 8'd3, INJ_NONE, 1'b1, 1'b0, 1'b0};
		table_q[7] = '{8'hC3, 8'd0, INJ_BAD_STOP, 1'b0, 1'b0, 1'b1};
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		assert (got === exp)
		else fail_now($sformatf("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	task automatic step();
		@(posedge Clk);
		#1;
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_bit()};
		end
		return b;
	endfunction

	// Bit k of a frame on the line, counted from the start bit
	function automatic logic frame_bit(input logic [7:0] data, input int k);
		logic [7:0] sh;
		sh = data << (k - 1);
		if (k == 0) begin
			return 1'b0;
		end else if (k <= DATA_BITS) begin
			return sh[DATA_BITS-1];
		end else if (k == DATA_BITS + 1) begin
			return ^data;
		end else begin
			return 1'b1;
		end
	endfunction

	task automatic check_tx_frame(input logic [7:0] data);
		int waited;
		waited = 0;
		@(negedge Clk);
		while (tx !== 1'b0) begin
			if (waited > MAX_CTS_DELAY + 8) begin
				fail_now("No start bit appeared on tx after CTS went high");
			end else begin
				waited++;
				@(negedge Clk);
			end
		end
		repeat (CLKS_PER_BIT / 2) @(negedge Clk);
		for (int k = 0; k < FRAME_BITS; k++) begin
			check_value("tx", 8'(tx), 8'(frame_bit(data, k)));
			check_value("tx_busy", 8'(tx_busy), 8'h01);
			check_value("rx_valid", 8'(rx_valid), 8'h00);
			if (k < FRAME_BITS - 1) begin
				repeat (CLKS_PER_BIT) @(negedge Clk);
			end
		end
	endtask

	task automatic wait_rx_valid(input logic [7:0] data, input logic exp_par,
		input logic exp_frm);
		int waited;
		waited = 0;
		@(negedge Clk);
		while (rx_valid !== 1'b1) begin
			if (waited >= RX_TIMEOUT) begin
				fail_now("rx_valid did not pulse after the end of the frame");
			end else begin
				waited++;
				@(negedge Clk);
			end
		end
		check_value("rx_data", rx_data, data);
		check_value("rx_parity_err", 8'(rx_parity_err), 8'(exp_par));
		check_value("rx_frame_err", 8'(rx_frame_err), 8'(exp_frm));
		@(negedge Clk);
		// The strobe lasts one cycle and the byte stays put afterwards
		check_value("rx_valid", 8'(rx_valid), 8'h00);
		check_value("rx_data", rx_data, data);
	endtask

	task automatic run_loopback(input entry_t e);
		logic [7:0] other;
		other = rand_byte();
		if (other == e.data) begin
			other = ~e.data;
		end
		step();
		loop_en = 1'b1;
		check_value("tx_busy", 8'(tx_busy), 8'h00);
		tx_start = 1'b1;
		tx_data  = e.data;
		cts      = (e.cts_delay == 8'd0);
		step();
		tx_start = 1'b0;
		// Line must stay quiet while CTS holds the frame back
		for (int i = 0; i < int'(e.cts_delay); i++) begin
			@(negedge Clk);
			check_value("tx", 8'(tx), 8'h01);
			check_value("tx_busy", 8'(tx_busy), 8'h01);
			step();
		end
		cts = 1'b1;
		fork
			check_tx_frame(e.data);
			if (e.extra_start) begin
				step();
				step();
				tx_start = 1'b1;
				tx_data  = other;
				step();
				tx_start = 1'b0;
			end
		join
		wait_rx_valid(e.data, e.exp_parity_err, e.exp_frame_err);
		// A second frame from the ignored strobe would show up here
		repeat (2 * CLKS_PER_BIT) begin
			@(negedge Clk);
			check_value("tx_busy", 8'(tx_busy), 8'h00);
			check_value("tx", 8'(tx), 8'h01);
		end
	endtask

	task automatic inject_frame(input logic [7:0] data, input inject_t mode);
		logic b;
		step();
		loop_en = 1'b0;
		for (int k = 0; k < FRAME_BITS; k++) begin
			b = frame_bit(data, k);
			if (mode == INJ_BAD_PARITY && k == DATA_BITS + 1) begin
				b = ~b;
			end
			if (mode == INJ_BAD_STOP && k == FRAME_BITS - 1) begin
				b = 1'b0;
			end
			rx_drive = b;
			repeat (CLKS_PER_BIT) step();
		end
		rx_drive = 1'b1;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge Clk);
		fail_now("Watchdog timeout: the test sequence did not finish in time");
	end

	initial begin
		Rst      = 1'b1;
		tx_start = 1'b0;
		tx_data  = 8'h00;
		cts      = 1'b0;
		rx_drive = 1'b1;
		loop_en  = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk);
		#1;
		Rst = 1'b0;
		@(negedge Clk);
		check_value("tx", 8'(tx), 8'h01);
		check_value("tx_busy", 8'(tx_busy), 8'h00);
		check_value("rx_valid", 8'(rx_valid), 8'h00);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (table_q[i].mode == INJ_NONE) begin
				run_loopback(table_q[i]);
			end else begin
				inject_frame(table_q[i].data, table_q[i].mode);
				wait_rx_valid(table_q[i].data, table_q[i].exp_parity_err,
					table_q[i].exp_frame_err);
			end
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/uart_pkg.sv
verilog/tx_control.sv
verilog/tx_frame_shifter.sv
verilog/rx_frame_sampler.sv
verilog/uart_top.sv
testbench/uart_tb.sv

// ==== verilog/rx_frame_sampler.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_frame_sampler (
	input  logic                           Clk,
	input  logic                           Rst,
	input  logic                           rx,
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,
	output logic                           rx_valid,
	output logic                           rx_parity_err,
	output logic                           rx_frame_err
);

	import uart_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;

	rx_state_t            state;
	logic [CLK_CNT_W-1:0] clk_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic                 last_bit;

	// The register keeps every bit after the start bit except the one being sampled
	logic [FRAME_BITS-3:0] shreg;
	logic [FRAME_BITS-2:0] shreg_next;

	// Two-flop synchronizer plus one more stage for edge detection
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign shreg_next = {shreg, rx_sync};
	assign last_bit   = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 2));

	// Sequencing
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			state         <= RX_IDLE;
			clk_cnt       <= '0;
			bit_cnt       <= '0;
			rx_valid      <= 1'b0;
			rx_parity_err <= 1'b0;
			rx_frame_err  <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			unique case (state)
				RX_IDLE: begin
					if (rx_prev && !rx_sync) begin
						// The edge is seen one clock into the start bit
						state   <= RX_START;
						clk_cnt <= CLK_CNT_W'(1);
					end
				end
				RX_START: begin
					if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// A start bit that is high again by mid-bit was a glitch
						state <= rx_sync ? RX_IDLE : RX_BITS;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_BITS: begin
					if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							state         <= RX_IDLE;
							rx_valid      <= 1'b1;
							rx_parity_err <= (^shreg_next[FRAME_BITS-2 -: DATA_BITS])
								!= shreg_next[STOP_BITS];
							rx_frame_err  <= ~&shreg_next[STOP_BITS-1:0];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// Sampled bits and the received byte
	always_ff @(posedge Clk) begin
		if (state == RX_BITS && clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
			shreg <= shreg_next[FRAME_BITS-3:0];
			if (last_bit) begin
				rx_data <= shreg_next[FRAME_BITS-2 -: DATA_BITS];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tx_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_control (
	input  logic Clk,
	input  logic Rst,
	input  logic tx_start,
	input  logic cts,
	input  logic frame_done,
	output logic load,
	output logic go,
	output logic tx_busy
);

	import uart_pkg::*;

	tx_state_t state;
	tx_state_t state_next;

	// State register
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			state <= TX_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Next state
	always_comb begin
		state_next = state;
		unique case (state)
			TX_IDLE: begin
				// Requests are only taken here and a strobe while busy is dropped
				if (tx_start) begin
					state_next = TX_WAIT_CTS;
				end
			end
			TX_WAIT_CTS: begin
				if (cts) begin
					state_next = TX_SEND;
				end
			end
			TX_SEND: begin
				// CTS is no longer looked at once the frame is on the line
				if (frame_done) begin
					state_next = TX_IDLE;
				end
			end
			default: begin
				state_next = TX_IDLE;
			end
		endcase
	end

	// Load captures the byte in the same cycle as the accepted request
	assign load = (state == TX_IDLE) && tx_start;

	// Go fires in the first cycle CTS is seen high while waiting
	assign go = (state == TX_WAIT_CTS) && cts;

	// Busy covers both the CTS wait and the frame itself
	assign tx_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

// ==== verilog/tx_frame_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_frame_shifter (
	input  logic                           Clk,
	input  logic                           Rst,
	input  logic                           load,
	input  logic                           go,
	input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
	output logic                           tx,
	output logic                           frame_done
);

	import uart_pkg::*;

	logic [FRAME_BITS-1:0] frame_q;
	logic                  active;
	logic [CLK_CNT_W-1:0]  clk_cnt;
	logic [BIT_CNT_W-1:0]  bit_idx;
	logic                  period_end;

	// The parity bit makes the data plus parity an even count of ones
	always_ff @(posedge Clk) begin
		if (load) begin
			frame_q <= {1'b0, tx_data, ^tx_data, {STOP_BITS{1'b1}}};
		end
	end

	assign period_end = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

	// The bit index walks from the start bit down to the last stop bit
	always_ff @(posedge Clk or posedge Rst) begin
		if (Rst) begin
			tx      <= 1'b1;
			active  <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (go && !active) begin
				active  <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= BIT_CNT_W'(FRAME_BITS - 1);
				tx      <= frame_q[FRAME_BITS-1];
			end else if (active) begin
				if (period_end) begin
					clk_cnt <= '0;
					if (bit_idx == '0) begin
						// Last stop bit has had its full period so the line goes quiet
						active <= 1'b0;
						tx     <= 1'b1;
					end else begin
						bit_idx <= bit_idx - 1'b1;
						tx      <= frame_q[bit_idx - 1'b1];
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
		end
	end

	// High in the final clock of the last stop bit
	assign frame_done = active && period_end && (bit_idx == '0);

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	// A frame is a start bit, the data MSB first, even parity and the stop bits
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;
	localparam int FRAME_BITS = 1 + DATA_BITS + 1 + STOP_BITS;

	// Clocks per serial bit must be even and at least 4 so the receiver has a mid-bit point
	localparam int CLKS_PER_BIT = 4;

	// Counter widths
	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);

	// Transmit controller states
	typedef enum logic [1:0] {
		TX_IDLE     = 2'b00,
		TX_WAIT_CTS = 2'b01,
		TX_SEND     = 2'b10
	} tx_state_t;

	// Receive sampler states
	typedef enum logic [1:0] {
		RX_IDLE  = 2'b00,
		RX_START = 2'b01,
		RX_BITS  = 2'b10
	} rx_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_top (
	input  logic                           Clk,
	input  logic                           Rst,
	input  logic                           tx_start,
	input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
	input  logic                           cts,
	output logic                           tx,
	output logic                           tx_busy,
	input  logic                           rx,
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,
	output logic                           rx_valid,
	output logic                           rx_parity_err,
	output logic                           rx_frame_err
);

	logic load;
	logic go;
	logic frame_done;

	// Transmit sequencing and request handling
	tx_control tx_control_i (
		.Clk        (Clk),
		.Rst        (Rst),
		.tx_start   (tx_start),
		.cts        (cts),
		.frame_done (frame_done),
		.load       (load),
		.go         (go),
		.tx_busy    (tx_busy)
	);

	// Transmit datapath
	tx_frame_shifter tx_frame_shifter_i (
		.Clk        (Clk),
		.Rst        (Rst),
		.load       (load),
		.go         (go),
		.tx_data    (tx_data),
		.tx         (tx),
		.frame_done (frame_done)
	);

	// Receiver runs on its own
	rx_frame_sampler rx_frame_sampler_i (
		.Clk           (Clk),
		.Rst           (Rst),
		.rx            (rx),
		.rx_data       (rx_data),
		.rx_valid      (rx_valid),
		.rx_parity_err (rx_parity_err),
		.rx_frame_err  (rx_frame_err)
	);

endmodule

`default_nettype wire
